/* sim/rom_ctrl_tests.txt */
// Word 0: record count. Next 16 words: base ROM image, address 0 first.
// Then one record per line: corrupt address, XOR mask, bus read address.
00000005
00000001
80000000
12345678
FFFFFFFF
00000010
00000003
00000000
FFFFFFFF
00000100
A5A5A5A5
00000000
0000000F
00000124
A5A5A5A1
48D159E0
0000000F
00000000 00000000 00000005
00000003 00000100 0000000C
0000000D 80000000 0000000D
0000000B FFFFFFFF 00000000
0000000F 00000001 00000009

/* files.f */
source/rom_ctrl_pkg.sv
source/rom_ctrl_counter.sv
source/rom_ctrl_hash.sv
source/rom_ctrl_regs.sv
source/rom_ctrl_compare.sv
source/rom_ctrl_fsm.sv
source/rom_ctrl_mux.sv
source/rom_ctrl_top.sv
sim/tb_clock_gen.sv
sim/rom_ctrl_assertions.sv
sim/rom_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := rom_ctrl_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/rom_ctrl_tb.sv */
// Must run from the project root, since the tests file is read by a relative path
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_tb;

  localparam int MaxWait     = 500;
  localparam int FileWords   = 64;
  localparam int ImageBase   = 1;
  localparam int RecordBase  = ImageBase + rom_ctrl_pkg::RomDepth;
  localparam int RecordWords = 3;
  localparam int MaxRecords  = (FileWords - RecordBase) / RecordWords;

  logic                    clk;
  logic                    rst_n;
  logic                    rst_req  = 1'b0;
  logic                    bus_req  = 1'b0;
  rom_ctrl_pkg::rom_addr_t bus_addr = '0;
  rom_ctrl_pkg::rom_word_t rom_data = '0;

  logic                    rom_req;
  rom_ctrl_pkg::rom_addr_t rom_addr;
  logic                    bus_gnt;
  logic                    bus_rvalid;
  rom_ctrl_pkg::rom_word_t bus_rdata;
  rom_ctrl_pkg::mubi4_t    check_done;
  rom_ctrl_pkg::mubi4_t    check_good;
  logic                    keymgr_valid;
  rom_ctrl_pkg::digest_t   keymgr_digest;
  logic                    alert;

  // Word 0 is the record count, then the base image, then the records
  logic [31:0]             tests_mem [0:FileWords-1];
  rom_ctrl_pkg::rom_word_t rom_mem [0:rom_ctrl_pkg::RomDepth-1];

  logic                    rom_req_q  = 1'b0;
  rom_ctrl_pkg::rom_addr_t rom_addr_q = '0;
  logic [15:0]             lfsr;
  int                      errors;
  int                      tests_run;
  int                      tests_failed;
  int                      alert_count = 0;

  tb_clock_gen u_clock_gen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  rom_ctrl_top u_rom_ctrl_top (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .bus_req_i       (bus_req),
    .bus_addr_i      (bus_addr),
    .rom_data_i      (rom_data),
    .rom_req_o       (rom_req),
    .rom_addr_o      (rom_addr),
    .bus_gnt_o       (bus_gnt),
    .bus_rvalid_o    (bus_rvalid),
    .bus_rdata_o     (bus_rdata),
    .check_done_o    (check_done),
    .check_good_o    (check_good),
    .keymgr_valid_o  (keymgr_valid),
    .keymgr_digest_o (keymgr_digest),
    .alert_o         (alert)
  );

  bind rom_ctrl_fsm rom_ctrl_assertions u_fsm_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .hash_vld_i  (hash_vld_o),
    .hash_last_i (hash_last_o),
    .hash_rdy_i  (hash_rdy_i),
    .state_i     (state_q)
  );

  // The ROM model captures the request on the rising edge and drives the word
  // on the next falling edge, one cycle after the request
  always @(posedge clk) begin
    rom_req_q  <= rom_req;
    rom_addr_q <= rom_addr;
  end

  always @(negedge clk) begin
    if (rom_req_q) begin
      rom_data <= rom_mem[rom_addr_q];
    end
  end

  // Counts every cycle with the alert up, so a test can compare before and after
  always @(negedge clk) begin
    if (rst_n && alert) begin
      alert_count <= alert_count + 1;
    end
  end

  // 16-bit Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // Reference digest of the current ROM image by the rotate-and-XOR rule
  function automatic rom_ctrl_pkg::digest_t hash_image();
    rom_ctrl_pkg::digest_t   d;
    rom_ctrl_pkg::rom_word_t w;
    int                      k;
    d = '0;
    for (int i = 0; i < rom_ctrl_pkg::TopStart; i++) begin
      k = i % rom_ctrl_pkg::TopCount;
      w = d[32*k +: 32];
      d[32*k +: 32] = {w[30:0], w[31]} ^ rom_mem[i];
    end
    return d;
  endfunction

  task automatic check_mubi(input string what, input rom_ctrl_pkg::mubi4_t got,
                            input rom_ctrl_pkg::mubi4_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_digest(input string what, input rom_ctrl_pkg::digest_t got,
                              input rom_ctrl_pkg::digest_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input rom_ctrl_pkg::rom_word_t got,
                            input rom_ctrl_pkg::rom_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input rom_ctrl_pkg::rom_addr_t got,
                            input rom_ctrl_pkg::rom_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Pulses the restart request and waits for the reset to be released
  task automatic apply_reset(output logic ok);
    ok = 1'b0;
    @(negedge clk);
    // A bus request is held through reset and must not be granted
    bus_req = 1'b1;
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    for (int c = 0; c < MaxWait && !ok; c++) begin
      @(negedge clk);
      #1;
      ok = rst_n;
    end
    if (!ok) begin
      errors++;
      $display("Timeout: reset was still asserted after %0d cycles", MaxWait);
    end
  endtask

  // Throws random bus requests at the DUT while the check runs
  // No grant may come back until done is reported
  task automatic wait_check_done(output logic ok);
    logic b;
    ok = 1'b0;
    for (int c = 0; c < MaxWait && !ok; c++) begin
      @(negedge clk);
      draw_bit(b);
      bus_req  = b;
      bus_addr = rom_ctrl_pkg::rom_addr_t'(c);
      #1;
      if (check_done === rom_ctrl_pkg::Mubi4True) begin
        ok = 1'b1;
      end else if (bus_gnt !== 1'b0) begin
        errors++;
        $display("** Error at %0t ns: bus grant given before the check finished", $time);
      end
    end
    bus_req = 1'b0;
    if (!ok) begin
      errors++;
      $display("Timeout: the check did not finish within %0d cycles", MaxWait);
    end
  endtask

  // One bus read after release; the data shows one cycle after the grant
  task automatic bus_read(input rom_ctrl_pkg::rom_addr_t a);
    @(negedge clk);
    bus_req  = 1'b1;
    bus_addr = a;
    #1;
    check_bit("bus_gnt_o", bus_gnt, 1'b1);
    @(negedge clk);
    bus_req = 1'b0;
    #1;
    check_bit("bus_rvalid_o", bus_rvalid, 1'b1);
    check_word("bus_rdata_o", bus_rdata, rom_mem[a]);
  endtask

  task automatic run_test(input int r);
    rom_ctrl_pkg::rom_addr_t bad_addr;
    rom_ctrl_pkg::rom_addr_t rd_addr;
    rom_ctrl_pkg::rom_word_t mask;
    rom_ctrl_pkg::digest_t   base_dig;
    rom_ctrl_pkg::digest_t   ref_dig;
    rom_ctrl_pkg::digest_t   top_dig;
    rom_ctrl_pkg::mubi4_t    exp_good;
    logic                    ok;
    int                      err0;
    int                      alerts0;
    err0 = errors;
    for (int i = 0; i < rom_ctrl_pkg::RomDepth; i++) begin
      rom_mem[i] = tests_mem[ImageBase + i];
    end
    base_dig = hash_image();
    bad_addr = rom_ctrl_pkg::rom_addr_t'(tests_mem[RecordBase + RecordWords*r]);
    mask     = tests_mem[RecordBase + RecordWords*r + 1];
    rd_addr  = rom_ctrl_pkg::rom_addr_t'(tests_mem[RecordBase + RecordWords*r + 2]);
    rom_mem[bad_addr] = rom_mem[bad_addr] ^ mask;
    ref_dig = hash_image();
    // The image is good only if its top words hold its own digest
    for (int k = 0; k < rom_ctrl_pkg::TopCount; k++) begin
      top_dig[32*k +: 32] = rom_mem[rom_ctrl_pkg::TopStart + k];
    end
    exp_good = (top_dig == ref_dig) ? rom_ctrl_pkg::Mubi4True : rom_ctrl_pkg::Mubi4False;

    apply_reset(ok);
    if (ok) begin
      // Nothing has been clocked since release, so these are the reset values
      check_mubi("check_done_o after reset", check_done, rom_ctrl_pkg::Mubi4False);
      check_mubi("check_good_o after reset", check_good, rom_ctrl_pkg::Mubi4False);
      check_bit("alert_o after reset", alert, 1'b0);
      check_bit("keymgr_valid_o after reset", keymgr_valid, 1'b0);
      check_bit("bus_gnt_o after reset", bus_gnt, 1'b0);
      // The first ROM read of the check goes out on the first clock
      check_bit("rom_req_o after reset", rom_req, 1'b1);
      check_addr("rom_addr_o after reset", rom_addr, '0);
      alerts0 = alert_count;
      wait_check_done(ok);
    end
    if (ok) begin
      check_mubi("check_good_o", check_good, exp_good);
      check_bit("keymgr_valid_o", keymgr_valid, 1'b1);
      check_digest("keymgr_digest_o", keymgr_digest, ref_dig);
      if (alert_count != alerts0) begin
        errors++;
        $display("Alert was raised during the check of test %0d", r);
      end
      // A changed low word must move the digest away from the base one
      if (bad_addr < rom_ctrl_pkg::TopStart && mask != '0 && keymgr_digest == base_dig) begin
        errors++;
        $display("** Error at %0t ns: digest did not change for a corrupt low word", $time);
      end
      bus_read(rd_addr);
    end
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("test %0d: corrupt %0d mask %h: FAILED", r, bad_addr, mask);
    end else begin
      $display("test %0d: corrupt %0d mask %h: passed", r, bad_addr, mask);
    end
  endtask

  initial begin
    int num;
    lfsr         = 16'd37179;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < FileWords; i++) begin
      tests_mem[i] = '0;
    end
    $readmemh("sim/rom_ctrl_tests.txt", tests_mem);
    num = int'(tests_mem[0]);
    if (num < 1 || num > MaxRecords) begin
      errors++;
      $display("The tests file gives %0d records, which is not usable", num);
      num = 0;
    end
    for (int r = 0; r < num; r++) begin
      run_test(r);
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rom_ctrl_assertions.sv */
// Bound into the checker FSM; checks hold only while reset is released
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_assertions (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire logic                     hash_vld_i,
  input wire logic                     hash_last_i,
  input wire logic                     hash_rdy_i,
  input wire rom_ctrl_pkg::fsm_state_e state_i
);

  // The last marker only means something on a word that is on offer
  last_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hash_last_i |-> hash_vld_i)
    else $error("hash last seen without valid");

  // An offered word may not be withdrawn before the engine takes it
  valid_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (hash_vld_i && !hash_rdy_i) |=> hash_vld_i)
    else $error("hash valid dropped before ready");

  // Done is terminal until the next reset
  done_is_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == rom_ctrl_pkg::Done) |=> (state_i == rom_ctrl_pkg::Done))
    else $error("FSM left the Done state");

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// Free-running 10 ns clock; reset is held for 16 cycles at start and again after each restart request
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  input  wire logic rst_req_i,
  output logic      clk_o,
  output logic      rst_no
);

  initial clk_o = 1'b0;

  always #5 clk_o = ~clk_o;

  // Reset asserts at once and releases on a falling edge after 16 rising edges
  always begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
    // Sit here until the testbench asks for a fresh reset
    @(posedge rst_req_i);
  end

endmodule

`default_nettype wire

/* source/rom_ctrl_top.sv */
// The ROM array sits outside and must answer each rom_req_o with data one cycle later
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     bus_req_i,
  input  wire rom_ctrl_pkg::rom_addr_t  bus_addr_i,
  input  wire rom_ctrl_pkg::rom_word_t  rom_data_i,
  output logic                          rom_req_o,
  output rom_ctrl_pkg::rom_addr_t       rom_addr_o,
  output logic                          bus_gnt_o,
  output logic                          bus_rvalid_o,
  output rom_ctrl_pkg::rom_word_t       bus_rdata_o,
  output rom_ctrl_pkg::mubi4_t          check_done_o,
  output rom_ctrl_pkg::mubi4_t          check_good_o,
  output logic                          keymgr_valid_o,
  output rom_ctrl_pkg::digest_t         keymgr_digest_o,
  output logic                          alert_o
);

  // Counter side
  rom_ctrl_pkg::rom_addr_t   read_addr;
  rom_ctrl_pkg::rom_addr_t   data_addr;
  logic                      read_req;
  logic                      counter_done;
  logic                      counter_lnt;
  logic                      data_rdy;

  // Hash side
  rom_ctrl_pkg::digest_t     hash_digest;
  logic                      hash_vld;
  logic                      hash_last;
  logic                      hash_rdy;
  logic                      hash_done;

  // Registers and checker
  rom_ctrl_pkg::digest_t     digest;
  rom_ctrl_pkg::digest_t     exp_digest;
  rom_ctrl_pkg::digest_idx_t exp_idx;
  rom_ctrl_pkg::mubi4_t      checker_good;
  rom_ctrl_pkg::mubi4_t      check_done;
  logic                      exp_vld;
  logic                      start;
  logic                      checker_done;
  logic                      checker_alert;

  rom_ctrl_counter u_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_rdy_i    (data_rdy),
    .read_req_o    (read_req),
    .done_o        (counter_done),
    .last_nontop_o (counter_lnt),
    .read_addr_o   (read_addr),
    .data_addr_o   (data_addr)
  );

  // The hash engine reads the ROM data straight off the port
  rom_ctrl_hash u_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .vld_i    (hash_vld),
    .last_i   (hash_last),
    .data_i   (rom_data_i),
    .rdy_o    (hash_rdy),
    .done_o   (hash_done),
    .digest_o (hash_digest)
  );

  rom_ctrl_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .digest_vld_i (hash_done),
    .digest_i     (hash_digest),
    .exp_vld_i    (exp_vld),
    .exp_idx_i    (exp_idx),
    .exp_word_i   (rom_data_i),
    .digest_o     (digest),
    .exp_digest_o (exp_digest)
  );

  rom_ctrl_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .done_o       (checker_done),
    .alert_o      (checker_alert),
    .good_o       (checker_good)
  );

  rom_ctrl_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .counter_done_i  (counter_done),
    .counter_lnt_i   (counter_lnt),
    .hash_rdy_i      (hash_rdy),
    .hash_done_i     (hash_done),
    .checker_done_i  (checker_done),
    .checker_alert_i (checker_alert),
    .read_req_i      (read_req),
    .data_addr_i     (data_addr),
    .checker_good_i  (checker_good),
    .hash_vld_o      (hash_vld),
    .hash_last_o     (hash_last),
    .data_rdy_o      (data_rdy),
    .start_o         (start),
    .exp_vld_o       (exp_vld),
    .keymgr_valid_o  (keymgr_valid_o),
    .alert_o         (alert_o),
    .exp_idx_o       (exp_idx),
    .check_done_o    (check_done),
    .check_good_o    (check_good_o)
  );

  // The bus gets the ROM port once the check reports done
  rom_ctrl_mux u_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .release_i    (check_done),
    .chk_req_i    (read_req),
    .bus_req_i    (bus_req_i),
    .chk_addr_i   (read_addr),
    .bus_addr_i   (bus_addr_i),
    .rom_data_i   (rom_data_i),
    .rom_req_o    (rom_req_o),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .rom_addr_o   (rom_addr_o),
    .bus_rdata_o  (bus_rdata_o)
  );

  assign check_done_o    = check_done;
  assign keymgr_digest_o = digest;

endmodule

`default_nettype wire

/* source/rom_ctrl_mux.sv */
// Bus grants are combinational and the ROM must return data one cycle after each request
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_mux (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire rom_ctrl_pkg::mubi4_t     release_i,
  input  wire logic                     chk_req_i,
  input  wire logic                     bus_req_i,
  input  wire rom_ctrl_pkg::rom_addr_t  chk_addr_i,
  input  wire rom_ctrl_pkg::rom_addr_t  bus_addr_i,
  input  wire rom_ctrl_pkg::rom_word_t  rom_data_i,
  output logic                          rom_req_o,
  output logic                          bus_gnt_o,
  output logic                          bus_rvalid_o,
  output rom_ctrl_pkg::rom_addr_t       rom_addr_o,
  output rom_ctrl_pkg::rom_word_t       bus_rdata_o
);

  logic sel_bus;
  logic rvalid_q;

  // Any value other than true keeps the checker in charge
  assign sel_bus = release_i == rom_ctrl_pkg::Mubi4True;

  assign rom_req_o  = sel_bus ? bus_req_i : chk_req_i;
  assign rom_addr_o = sel_bus ? bus_addr_i : chk_addr_i;
  assign bus_gnt_o  = sel_bus & bus_req_i;

  // Read data comes back one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_gnt_o;
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rvalid_q ? rom_data_i : '0;

endmodule

`default_nettype wire

/* source/rom_ctrl_fsm.sv */
// Checker control for a single pass after reset; the Invalid state is terminal until reset
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_fsm (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      counter_done_i,
  input  wire logic                      counter_lnt_i,
  input  wire logic                      hash_rdy_i,
  input  wire logic                      hash_done_i,
  input  wire logic                      checker_done_i,
  input  wire logic                      checker_alert_i,
  input  wire logic                      read_req_i,
  input  wire rom_ctrl_pkg::rom_addr_t   data_addr_i,
  input  wire rom_ctrl_pkg::mubi4_t      checker_good_i,
  output logic                           hash_vld_o,
  output logic                           hash_last_o,
  output logic                           data_rdy_o,
  output logic                           start_o,
  output logic                           exp_vld_o,
  output logic                           keymgr_valid_o,
  output logic                           alert_o,
  output rom_ctrl_pkg::digest_idx_t      exp_idx_o,
  output rom_ctrl_pkg::mubi4_t           check_done_o,
  output rom_ctrl_pkg::mubi4_t           check_good_o
);

  rom_ctrl_pkg::fsm_state_e state_d;
  rom_ctrl_pkg::fsm_state_e state_q;
  rom_ctrl_pkg::rom_addr_t  rel_addr;
  logic                     fsm_alert;
  logic                     in_done;
  logic                     counter_drop;
  logic                     reading_top;
  logic                     vld_d;
  logic                     vld_q;
  logic                     enter_q;
  logic                     start_q;

  assign in_done = state_q == rom_ctrl_pkg::Done;

  // The counter must stay done once the check has finished
  // A drop means someone is moving the read address behind the checker
  assign counter_drop = in_done & ~counter_done_i;

  // The graph is linear apart from the race between the top reads and the hash result
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      rom_ctrl_pkg::ReadingLow: begin
        // Leave once the last low word has gone into the hash engine
        if (counter_lnt_i && hash_rdy_i && vld_q) begin
          state_d = rom_ctrl_pkg::ReadingHigh;
        end
      end
      rom_ctrl_pkg::ReadingHigh: begin
        case ({hash_done_i, counter_done_i})
          2'b01:   state_d = rom_ctrl_pkg::RomAhead;
          2'b10:   state_d = rom_ctrl_pkg::HashAhead;
          2'b11:   state_d = rom_ctrl_pkg::Checking;
          default: state_d = rom_ctrl_pkg::ReadingHigh;
        endcase
      end
      rom_ctrl_pkg::RomAhead: begin
        if (hash_done_i) begin
          state_d = rom_ctrl_pkg::Checking;
        end
      end
      rom_ctrl_pkg::HashAhead: begin
        if (counter_done_i) begin
          state_d = rom_ctrl_pkg::Checking;
        end
      end
      rom_ctrl_pkg::Checking: begin
        if (checker_done_i) begin
          state_d = rom_ctrl_pkg::Done;
        end
      end
      rom_ctrl_pkg::Done: begin
        // Terminal state
        state_d = rom_ctrl_pkg::Done;
      end
      default: begin
        // Invalid and the unused encoding both alert and stay put
        fsm_alert = 1'b1;
        state_d   = rom_ctrl_pkg::Invalid;
      end
    endcase

    // Each done strobe may only arrive in the states that expect it
    if ((checker_done_i && !(state_q inside {rom_ctrl_pkg::Checking, rom_ctrl_pkg::Done})) ||
        (counter_done_i && state_q == rom_ctrl_pkg::ReadingLow) ||
        (hash_done_i && !(state_q inside {rom_ctrl_pkg::ReadingHigh, rom_ctrl_pkg::RomAhead})) ||
        counter_drop || checker_alert_i) begin
      state_d = rom_ctrl_pkg::Invalid;
    end
  end

  // Valid toward the hash engine rises after each low read and falls on ready
  // The last low word is still offered but no new word follows it
  always_comb begin
    vld_d = vld_q;
    if (hash_rdy_i) begin
      vld_d = 1'b0;
    end
    if (read_req_i && state_q == rom_ctrl_pkg::ReadingLow && !counter_lnt_i) begin
      vld_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rom_ctrl_pkg::ReadingLow;
      vld_q   <= 1'b0;
      enter_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      vld_q   <= vld_d;
      // enter_q marks the first cycle in Checking and start follows one cycle later
      enter_q <= (state_q != rom_ctrl_pkg::Checking) && (state_d == rom_ctrl_pkg::Checking);
      start_q <= enter_q;
    end
  end

  // The top reads are free running so the counter never waits on the hash engine there
  assign data_rdy_o  = hash_rdy_i |
                       (state_q inside {rom_ctrl_pkg::ReadingHigh, rom_ctrl_pkg::HashAhead});
  assign hash_vld_o  = vld_q;
  assign hash_last_o = counter_lnt_i;
  assign start_o     = start_q;

  // Snoop the top words into the expected digest while the counter is still running
  assign reading_top = (state_q inside {rom_ctrl_pkg::ReadingHigh, rom_ctrl_pkg::HashAhead}) &
                       ~counter_done_i;
  assign rel_addr    = data_addr_i - rom_ctrl_pkg::rom_addr_t'(rom_ctrl_pkg::TopStart);
  assign exp_vld_o   = reading_top;
  assign exp_idx_o   = rom_ctrl_pkg::digest_idx_t'(rel_addr);

  // Power management sees done from the state and good straight from the checker
  assign check_done_o   = in_done ? rom_ctrl_pkg::Mubi4True : rom_ctrl_pkg::Mubi4False;
  assign check_good_o   = checker_good_i;
  assign keymgr_valid_o = in_done;

  assign alert_o = fsm_alert | checker_alert_i | counter_drop;

endmodule

`default_nettype wire

/* source/rom_ctrl_compare.sv */
// Runs one comparison per reset; any later start raises a sticky alert
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_compare (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire rom_ctrl_pkg::digest_t  digest_i,
  input  wire rom_ctrl_pkg::digest_t  exp_digest_i,
  output logic                        done_o,
  output logic                        alert_o,
  output rom_ctrl_pkg::mubi4_t        good_o
);

  rom_ctrl_pkg::digest_idx_t idx_q;
  rom_ctrl_pkg::mubi4_t      good_q;
  rom_ctrl_pkg::rom_word_t   dig_word;
  rom_ctrl_pkg::rom_word_t   exp_word;
  logic                      busy_q;
  logic                      fin_q;
  logic                      done_q;
  logic                      alert_q;
  logic                      diff_q;
  logic                      word_diff;
  logic                      last_word;

  // The pair of words under test this cycle
  assign dig_word  = digest_i[32*idx_q +: 32];
  assign exp_word  = exp_digest_i[32*idx_q +: 32];
  assign word_diff = dig_word != exp_word;
  assign last_word = idx_q == rom_ctrl_pkg::digest_idx_t'(rom_ctrl_pkg::TopCount - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q   <= '0;
      good_q  <= rom_ctrl_pkg::Mubi4False;
      busy_q  <= 1'b0;
      fin_q   <= 1'b0;
      done_q  <= 1'b0;
      alert_q <= 1'b0;
      diff_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        // A second start means the control flow has gone wrong
        if (busy_q || fin_q) begin
          alert_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
          idx_q  <= '0;
          diff_q <= 1'b0;
        end
      end
      if (busy_q) begin
        idx_q  <= idx_q + 1'b1;
        diff_q <= diff_q | word_diff;
        if (last_word) begin
          busy_q <= 1'b0;
          fin_q  <= 1'b1;
          done_q <= 1'b1;
          // Good only becomes true if every word matched
          good_q <= (diff_q || word_diff) ? rom_ctrl_pkg::Mubi4False : rom_ctrl_pkg::Mubi4True;
        end
      end
    end
  end

  assign done_o  = done_q;
  assign good_o  = good_q;
  assign alert_o = alert_q;

endmodule

`default_nettype wire

/* source/rom_ctrl_regs.sv */
// Digest storage only; both registers read as zero until written after each reset
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_regs (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       digest_vld_i,
  input  wire rom_ctrl_pkg::digest_t      digest_i,
  input  wire logic                       exp_vld_i,
  input  wire rom_ctrl_pkg::digest_idx_t  exp_idx_i,
  input  wire rom_ctrl_pkg::rom_word_t    exp_word_i,
  output rom_ctrl_pkg::digest_t           digest_o,
  output rom_ctrl_pkg::digest_t           exp_digest_o
);

  rom_ctrl_pkg::digest_t digest_q;
  rom_ctrl_pkg::digest_t exp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
      exp_q    <= '0;
    end else begin
      // The hash engine presents the full digest with its done pulse
      if (digest_vld_i) begin
        digest_q <= digest_i;
      end
      // Expected words arrive one at a time as the top of the ROM is read
      if (exp_vld_i) begin
        exp_q[32*exp_idx_i +: 32] <= exp_word_i;
      end
    end
  end

  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;

endmodule

`default_nettype wire

/* source/rom_ctrl_hash.sv */
// Simple rotate-and-XOR digest, not cryptographic, which accepts one message per reset
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_hash (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     vld_i,
  input  wire logic                     last_i,
  input  wire rom_ctrl_pkg::rom_word_t  data_i,
  output logic                          rdy_o,
  output logic                          done_o,
  output rom_ctrl_pkg::digest_t         digest_o
);

  rom_ctrl_pkg::digest_t     acc_q;
  rom_ctrl_pkg::digest_idx_t idx_q;
  rom_ctrl_pkg::rom_word_t   cur_word;
  logic                      xfer;
  logic                      stall_q;
  logic                      closed_q;
  logic                      last_q;
  logic                      done_q;

  // A word moves when valid meets ready
  assign xfer = vld_i & rdy_o;

  // Ready drops for one cycle after every accepted word
  // and stays low once the last word has been taken
  assign rdy_o = ~stall_q & ~closed_q;

  // The accumulator word that the next input folds into
  assign cur_word = acc_q[32*idx_q +: 32];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q    <= '0;
      idx_q    <= '0;
      stall_q  <= 1'b0;
      closed_q <= 1'b0;
      last_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      stall_q <= xfer;
      // Two-stage delay from the last transfer to the done pulse
      last_q  <= xfer & last_i;
      done_q  <= last_q;
      if (xfer) begin
        // Rotate the selected word left by one and mix in the new data
        acc_q[32*idx_q +: 32] <= {cur_word[30:0], cur_word[31]} ^ data_i;
        // The index wraps at TopCount because the index type is exactly that wide
        idx_q <= idx_q + 1'b1;
        if (last_i) begin
          closed_q <= 1'b1;
        end
      end
    end
  end

  assign done_o   = done_q;
  assign digest_o = acc_q;

endmodule

`default_nettype wire

/* source/rom_ctrl_counter.sv */
// Assumes the ROM answers every request with data one cycle later and never stalls
`timescale 1ns/1ns
`default_nettype none

module rom_ctrl_counter (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               data_rdy_i,
  output logic                    read_req_o,
  output logic                    done_o,
  output logic                    last_nontop_o,
  output rom_ctrl_pkg::rom_addr_t read_addr_o,
  output rom_ctrl_pkg::rom_addr_t data_addr_o
);

  rom_ctrl_pkg::rom_addr_t addr_q;
  logic                    vld_q;
  logic                    done_q;
  logic                    go;
  logic                    at_top;

  // Data for addr_q sits on the ROM port from the second cycle onward
  assign go     = data_rdy_i & vld_q & ~done_q;
  assign at_top = addr_q == rom_ctrl_pkg::rom_addr_t'(rom_ctrl_pkg::RomDepth - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      vld_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // The first request goes out right after reset so data follows one cycle later
      vld_q <= 1'b1;
      if (go) begin
        if (at_top) begin
          done_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  // Read one word ahead so that the next data is ready when the current word is taken
  assign read_addr_o = (go && !at_top) ? addr_q + 1'b1 : addr_q;
  // No request is issued once the top word has been taken
  assign read_req_o  = ~done_q & ~(go & at_top);

  assign data_addr_o   = addr_q;
  assign done_o        = done_q;
  // The last word that belongs to the hashed part of the ROM
  assign last_nontop_o = addr_q == rom_ctrl_pkg::rom_addr_t'(rom_ctrl_pkg::TopStart - 1);

endmodule

`default_nettype wire

/* source/rom_ctrl_pkg.sv */
// Shared widths, types and constants for a 16-word ROM whose top 4 words hold the digest
`default_nettype none

package rom_ctrl_pkg;

  // ROM geometry
  localparam int RomDepth = 16;
  localparam int TopCount = 4;
  // The expected digest starts at this address and runs to the top of the ROM
  localparam int TopStart = RomDepth - TopCount;

  // One address and one data word of the ROM
  typedef logic [3:0]  rom_addr_t;
  typedef logic [31:0] rom_word_t;

  // The whole digest with word 0 in the low 32 bits
  typedef logic [TopCount*32-1:0] digest_t;
  // Selects one word of the digest
  typedef logic [1:0] digest_idx_t;

  // A 4-bit boolean used toward power management
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t Mubi4True  = 4'h6;
  localparam mubi4_t Mubi4False = 4'h9;

  // States of the checker FSM
  typedef enum logic [2:0] {
    ReadingLow,
    ReadingHigh,
    RomAhead,
    HashAhead,
    Checking,
    Done,
    Invalid
  } fsm_state_e;

endpackage

`default_nettype wire
